//--- filelist.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/alu.sv
src/shifter.sv
src/alu_misc.sv
src/reg_file.sv
src/issue_stage.sv
src/alu_core_top.sv
bench/alu_core_checker.sv
bench/alu_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= alu_core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG  := Simulation failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(SIM_LOG) 2>&1; \
	status=$$?; \
	cat $(SIM_LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(SIM_LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- bench/alu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core_tb;

    typedef logic [isa_pkg::data_width-1:0]     word_t;
    typedef logic [isa_pkg::reg_addr_width-1:0] reg_idx_t;
    typedef logic [isa_pkg::shamt_width-1:0]    shamt_t;
    typedef logic [isa_pkg::imm_width-1:0]      imm_t;

    logic            clock       = 1'b0;
    logic            reset       = 1'b0;
    logic            instr_valid = 1'b0;
    isa_pkg::instr_t instr       = '0;
    pipe_pkg::wb_t   wb;

    // Reference model state
    word_t           model_regs [isa_pkg::reg_count];
    word_t           init_values [isa_pkg::reg_count];
    pipe_pkg::wb_t   expect_q [$];
    pipe_pkg::wb_t   expect_now   = '0;
    int unsigned     checks       = 0;
    int unsigned     errors       = 0;
    int unsigned     random_slots = 400;

    alu_core_top dut0 (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb)
    );

    initial begin
        forever #20 clock = ~clock;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic word_t sign_extend(imm_t imm);
        return {{(isa_pkg::data_width-isa_pkg::imm_width){imm[isa_pkg::imm_width-1]}}, imm};
    endfunction

    // Signed result no longer fits in one word
    function automatic logic overflows(word_t a, word_t b, logic subtract);
        logic [isa_pkg::data_width:0] wide;
        wide = subtract ? {a[isa_pkg::data_width-1], a} - {b[isa_pkg::data_width-1], b}
                        : {a[isa_pkg::data_width-1], a} + {b[isa_pkg::data_width-1], b};
        return wide[isa_pkg::data_width] != wide[isa_pkg::data_width-1];
    endfunction

    function automatic pipe_pkg::wb_t predict_writeback(isa_pkg::instr_t ins);
        word_t         a;
        word_t         b;
        pipe_pkg::wb_t res;
        a = model_regs[ins.rs];
        b = model_regs[ins.rt];
        res = '0;
        res.oper     = 1'b1;
        res.writereg = 1'b1;
        res.regdest  = ins.rd;
        case (ins.opcode)
            isa_pkg::add: begin
                res.value    = a + b;
                res.writereg = !overflows(a, b, 1'b0);
            end
            isa_pkg::addu: res.value = a + b;
            isa_pkg::sub: begin
                res.value    = a - b;
                res.writereg = !overflows(a, b, 1'b1);
            end
            isa_pkg::subu:  res.value = a - b;
            isa_pkg::and_r: res.value = a & b;
            isa_pkg::or_r:  res.value = a | b;
            isa_pkg::xor_r: res.value = a ^ b;
            isa_pkg::nor_r: res.value = ~(a | b);
            isa_pkg::slt:   res.value = word_t'($signed(a) < $signed(b));
            isa_pkg::sltu:  res.value = word_t'(a < b);
            isa_pkg::sll:   res.value = b << ins.shamt;
            isa_pkg::srl:   res.value = b >> ins.shamt;
            isa_pkg::sra:   res.value = word_t'($signed(b) >>> ins.shamt);
            default: begin
                // Immediate forms write rt
                res.regdest = ins.rt;
                case (ins.opcode)
                    isa_pkg::addi: begin
                        res.value    = a + sign_extend(ins.imm);
                        res.writereg = !overflows(a, sign_extend(ins.imm), 1'b0);
                    end
                    isa_pkg::addiu: res.value = a + sign_extend(ins.imm);
                    isa_pkg::andi:  res.value = a & word_t'(ins.imm);
                    isa_pkg::ori:   res.value = a | word_t'(ins.imm);
                    isa_pkg::xori:  res.value = a ^ word_t'(ins.imm);
                    isa_pkg::lui:   res.value = {ins.imm, imm_t'(0)};
                    default: begin
                        // nop
                        res.regdest  = '0;
                        res.writereg = 1'b0;
                    end
                endcase
            end
        endcase
        return res;
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic isa_pkg::instr_t make_instr(isa_pkg::opcode_e op, int rs, int rt,
                                                   int rd, int shamt, imm_t imm);
        isa_pkg::instr_t ins;
        ins.opcode = op;
        ins.rs     = reg_idx_t'(rs);
        ins.rt     = reg_idx_t'(rt);
        ins.rd     = reg_idx_t'(rd);
        ins.shamt  = shamt_t'(shamt);
        ins.imm    = imm;
        return ins;
    endfunction

    // Small register window so results are often read back
    function automatic isa_pkg::instr_t random_instr();
        isa_pkg::instr_t ins;
        ins.opcode = isa_pkg::opcode_e'(5'($urandom_range(int'(isa_pkg::sra), 0)));
        ins.rs     = reg_idx_t'($urandom_range(15, 0));
        ins.rt     = reg_idx_t'($urandom_range(15, 0));
        ins.rd     = reg_idx_t'($urandom_range(15, 0));
        ins.shamt  = shamt_t'($urandom);
        case ($urandom_range(7, 0))
            0:       ins.imm = 16'h7fff;
            1:       ins.imm = 16'h8000;
            default: ins.imm = imm_t'($urandom);
        endcase
        return ins;
    endfunction

    // One clock of stimulus where the model retires what the DUT writes at the next edge
    task automatic issue_slot(input logic valid, input isa_pkg::instr_t ins);
        pipe_pkg::wb_t head;
        @(posedge clock);
        head = '0;
        if (expect_q.size() == pipe_pkg::alu_stages + 1) begin
            head = expect_q.pop_front();
        end
        if (head.oper && head.writereg && head.regdest != '0) begin
            model_regs[head.regdest] = head.value;
        end
        expect_now = head;
        if (valid) begin
            expect_q.push_back(predict_writeback(ins));
            instr <= ins;
        end else begin
            expect_q.push_back('0);
            instr <= '0;
        end
        instr_valid <= valid;
    endtask

    // Upper halves first so each ori reads its lui after writeback
    task automatic load_registers();
        for (int r = 1; r < isa_pkg::reg_count; r++) begin
            issue_slot(1'b1, make_instr(isa_pkg::lui, 0, r, 0, 0,
                                        init_values[r][isa_pkg::data_width-1 -: isa_pkg::imm_width]));
        end
        for (int r = 1; r < isa_pkg::reg_count; r++) begin
            issue_slot(1'b1, make_instr(isa_pkg::ori, r, r, 0, 0,
                                        init_values[r][isa_pkg::imm_width-1:0]));
        end
    endtask

    task automatic sweep_shifts();
        for (int amount = 0; amount < isa_pkg::data_width; amount++) begin
            issue_slot(1'b1, make_instr(isa_pkg::sll, 0, 4, 0, amount, '0));
            issue_slot(1'b1, make_instr(isa_pkg::srl, 0, 4, 0, amount, '0));
            issue_slot(1'b1, make_instr(isa_pkg::sra, 0, 4, 0, amount, '0));
        end
    endtask

    task automatic force_overflows();
        issue_slot(1'b1, make_instr(isa_pkg::add, 1, 1, 5, 0, '0));
        issue_slot(1'b1, make_instr(isa_pkg::sub, 2, 1, 5, 0, '0));
        issue_slot(1'b1, make_instr(isa_pkg::addi, 1, 5, 0, 0, 16'h7fff));
        issue_slot(1'b1, make_instr(isa_pkg::addu, 1, 1, 6, 0, '0));
        issue_slot(1'b1, make_instr(isa_pkg::subu, 2, 1, 7, 0, '0));
        issue_slot(1'b1, make_instr(isa_pkg::addiu, 1, 8, 0, 0, 16'h7fff));
        repeat (5) issue_slot(1'b0, '0);
        // r5 still holds its loaded value
        issue_slot(1'b1, make_instr(isa_pkg::or_r, 5, 0, 9, 0, '0));
    endtask

    ////////////////////////////////////////
    // Checking and run control
    ////////////////////////////////////////

    always @(negedge clock) begin
        checks++;
        assert (wb === expect_now) else begin
            errors++;
            $display("MISMATCH at %0t ns: wb oper %0b dest %0d write %0b value %h,",
                     $time, wb.oper, wb.regdest, wb.writereg, wb.value,
                     " expected oper %0b dest %0d write %0b value %h",
                     expect_now.oper, expect_now.regdest, expect_now.writereg,
                     expect_now.value);
        end
    end

    initial begin : stimulus
        int          seed;
        int unsigned total;
        seed = 32'h4944_85b5;
        void'($urandom(seed));
        for (int r = 0; r < isa_pkg::reg_count; r++) begin
            init_values[r] = $urandom;
            model_regs[r]  = '0;
        end
        init_values[1] = 32'h7fff_ffff;
        init_values[2] = 32'h8000_0000;
        init_values[3] = 32'hffff_ffff;
        init_values[4] = 32'hf0f0_1234;
        repeat (2) @(posedge clock);
        reset <= 1'b1;
        load_registers();
        sweep_shifts();
        force_overflows();
        for (int i = 0; i < random_slots; i++) begin
            // About one slot in eight stays idle
            issue_slot($urandom_range(7, 0) != 0, random_instr());
        end
        repeat (8) issue_slot(1'b0, '0);
        @(posedge clock);
        total = errors + dut0.checker0.fail_count;
        $display("Summary: %0d checks, %0d mismatches, %0d checker failures",
                 checks, errors, dut0.checker0.fail_count);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int unsigned limit;
        // Reset, directed slots, random slots, drain and margin
        limit = 2 + 2 * (isa_pkg::reg_count - 1) + 3 * isa_pkg::data_width + 12
                + random_slots + 8 + 20;
        repeat (limit) @(posedge clock);
        $display("Watchdog timeout after %0d cycles: stimulus did not finish", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/alu_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core_checker (
    input logic          clock,
    input logic          reset,
    input logic          instr_valid,
    input pipe_pkg::wb_t wb
);

    // Failures seen so far for the testbench summary
    int unsigned fail_count = 0;

    ////////////////////////////////////////
    // Writeback timing
    ////////////////////////////////////////

    // One issue cycle plus the functional unit stages
    a_latency: assert property (@(posedge clock) disable iff (!reset)
        wb.oper == $past(instr_valid, pipe_pkg::alu_stages + 1))
    else begin
        fail_count++;
        $error("writeback valid does not follow the issue strobe");
    end

    ////////////////////////////////////////
    // Empty slots and reset
    ////////////////////////////////////////

    a_idle_no_write: assert property (@(posedge clock) !wb.oper |-> !wb.writereg)
    else begin
        fail_count++;
        $error("write enable set on an empty writeback slot");
    end

    a_idle_zero: assert property (@(posedge clock) !wb.oper |-> wb == '0)
    else begin
        fail_count++;
        $error("empty writeback slot carries a payload");
    end

    a_reset_clear: assert property (@(posedge clock) !reset |=> wb == '0)
    else begin
        fail_count++;
        $error("writeback not cleared by reset");
    end

endmodule

bind alu_core_top alu_core_checker checker0 (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .wb          (wb)
);

`default_nettype wire

//--- src/alu_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core_top (
    input  logic            clock,
    input  logic            reset,
    input  logic            instr_valid,
    input  isa_pkg::instr_t instr,
    output pipe_pkg::wb_t   wb
);

    logic [isa_pkg::reg_addr_width-1:0] raddr_a;
    logic [isa_pkg::reg_addr_width-1:0] raddr_b;
    logic [isa_pkg::data_width-1:0]     rdata_a;
    logic [isa_pkg::data_width-1:0]     rdata_b;
    pipe_pkg::issue_t                   iss;

    issue_stage issue0 (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .raddr_a     (raddr_a),
        .raddr_b     (raddr_b),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .iss         (iss)
    );

    // Writeback feeds the write port and the top-level output
    reg_file rf0 (
        .clock   (clock),
        .reset   (reset),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wb      (wb)
    );

    alu_misc fu0 (
        .clock (clock),
        .reset (reset),
        .iss   (iss),
        .wb    (wb)
    );

endmodule

`default_nettype wire

//--- src/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               instr_valid,
    input  isa_pkg::instr_t                    instr,
    output logic [isa_pkg::reg_addr_width-1:0] raddr_a,
    output logic [isa_pkg::reg_addr_width-1:0] raddr_b,
    input  logic [isa_pkg::data_width-1:0]     rdata_a,
    input  logic [isa_pkg::data_width-1:0]     rdata_b,
    output pipe_pkg::issue_t                   iss
);

    logic [isa_pkg::data_width-1:0] imm_sext;
    logic [isa_pkg::data_width-1:0] imm_zext;
    logic [isa_pkg::data_width-1:0] imm_upper;
    pipe_pkg::issue_t               next_iss;

    assign raddr_a = instr.rs;
    assign raddr_b = instr.rt;

    assign imm_sext  = {{(isa_pkg::data_width-isa_pkg::imm_width){instr.imm[isa_pkg::imm_width-1]}},
                        instr.imm};
    assign imm_zext  = {{(isa_pkg::data_width-isa_pkg::imm_width){1'b0}}, instr.imm};
    assign imm_upper = {instr.imm, {(isa_pkg::data_width-isa_pkg::imm_width){1'b0}}};

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    always_comb begin
        next_iss = '0;
        if (instr_valid) begin
            next_iss.oper     = 1'b1;
            next_iss.rega     = rdata_a;
            next_iss.regb     = rdata_b;
            next_iss.shamt    = instr.shamt;
            next_iss.imm_ext  = imm_sext;
            next_iss.regdest  = instr.rd;
            next_iss.writereg = 1'b1;
            next_iss.writeov  = 1'b1;
            next_iss.alu_op   = isa_pkg::alu_add;
            case (instr.opcode)
                isa_pkg::add:   next_iss.writeov = 1'b0;
                isa_pkg::addu:  next_iss.unsig = 1'b1;
                isa_pkg::sub: begin
                    next_iss.alu_op  = isa_pkg::alu_sub;
                    next_iss.writeov = 1'b0;
                end
                isa_pkg::subu: begin
                    next_iss.alu_op = isa_pkg::alu_sub;
                    next_iss.unsig  = 1'b1;
                end
                isa_pkg::and_r: next_iss.alu_op = isa_pkg::alu_and;
                isa_pkg::or_r:  next_iss.alu_op = isa_pkg::alu_or;
                isa_pkg::xor_r: next_iss.alu_op = isa_pkg::alu_xor;
                isa_pkg::nor_r: next_iss.alu_op = isa_pkg::alu_nor;
                isa_pkg::slt:   next_iss.alu_op = isa_pkg::alu_slt;
                isa_pkg::sltu: begin
                    next_iss.alu_op = isa_pkg::alu_slt;
                    next_iss.unsig  = 1'b1;
                end
                // Immediate forms write rt
                isa_pkg::addi, isa_pkg::addiu, isa_pkg::andi,
                isa_pkg::ori, isa_pkg::xori, isa_pkg::lui: begin
                    next_iss.sel_imm = 1'b1;
                    next_iss.regdest = instr.rt;
                    case (instr.opcode)
                        isa_pkg::addi:  next_iss.writeov = 1'b0;
                        isa_pkg::addiu: next_iss.unsig = 1'b1;
                        isa_pkg::andi: begin
                            next_iss.alu_op  = isa_pkg::alu_and;
                            next_iss.imm_ext = imm_zext;
                        end
                        isa_pkg::ori: begin
                            next_iss.alu_op  = isa_pkg::alu_or;
                            next_iss.imm_ext = imm_zext;
                        end
                        isa_pkg::xori: begin
                            next_iss.alu_op  = isa_pkg::alu_xor;
                            next_iss.imm_ext = imm_zext;
                        end
                        default: begin
                            next_iss.alu_op  = isa_pkg::alu_passb;
                            next_iss.imm_ext = imm_upper;
                        end
                    endcase
                end
                isa_pkg::sll, isa_pkg::srl, isa_pkg::sra: begin
                    next_iss.sel_shift = 1'b1;
                    next_iss.shift_op  = (instr.opcode == isa_pkg::sll) ? isa_pkg::sh_sll :
                                         (instr.opcode == isa_pkg::srl) ? isa_pkg::sh_srl :
                                                                          isa_pkg::sh_sra;
                end
                // nop and unknown codes pass a zero value and write nothing
                default: begin
                    next_iss.alu_op   = isa_pkg::alu_passb;
                    next_iss.sel_imm  = 1'b1;
                    next_iss.imm_ext  = '0;
                    next_iss.regdest  = '0;
                    next_iss.writereg = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            iss <= '0;
        end else begin
            iss <= next_iss;
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [isa_pkg::reg_addr_width-1:0] raddr_a,
    input  logic [isa_pkg::reg_addr_width-1:0] raddr_b,
    output logic [isa_pkg::data_width-1:0]     rdata_a,
    output logic [isa_pkg::data_width-1:0]     rdata_b,
    input  pipe_pkg::wb_t                      wb
);

    logic [isa_pkg::data_width-1:0] regs [isa_pkg::reg_count];
    logic                           wr_en;
    logic                           hit_a;
    logic                           hit_b;

    // Writes to register zero are dropped
    assign wr_en = wb.oper && wb.writereg && (wb.regdest != '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.regdest] <= wb.value;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // A write on the same edge is seen by the reading issue stage
    assign hit_a = wr_en && (wb.regdest == raddr_a);
    assign hit_b = wr_en && (wb.regdest == raddr_b);

    assign rdata_a = (raddr_a == '0) ? '0 : (hit_a ? wb.value : regs[raddr_a]);
    assign rdata_b = (raddr_b == '0) ? '0 : (hit_b ? wb.value : regs[raddr_b]);

endmodule

`default_nettype wire

//--- src/alu_misc.sv
`timescale 1ns/1ns
`default_nettype none

module alu_misc (
    input  logic             clock,
    input  logic             reset,
    input  pipe_pkg::issue_t iss,
    output pipe_pkg::wb_t    wb
);

    logic [isa_pkg::data_width-1:0] operand_b;
    logic [isa_pkg::data_width-1:0] alu_result;
    logic                           alu_overflow;
    logic [isa_pkg::data_width-1:0] shift_result;
    pipe_pkg::wb_t                  head;

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    assign operand_b = iss.sel_imm ? iss.imm_ext : iss.regb;

    alu alu0 (
        .a        (iss.rega),
        .b        (operand_b),
        .op       (iss.alu_op),
        .unsig    (iss.unsig),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // Shifts always act on the rt operand
    shifter shifter0 (
        .value    (iss.regb),
        .shift_op (iss.shift_op),
        .shamt    (iss.shamt),
        .result   (shift_result)
    );

    // Payload entering the first register stage
    always_comb begin
        head.oper    = iss.oper;
        head.regdest = iss.regdest;
        // Overflow cancels the write unless the opcode ignores it
        head.writereg = iss.writereg & (~alu_overflow | iss.writeov);
        head.value    = iss.sel_shift ? shift_result : alu_result;
    end

    ////////////////////////////////////////
    // Stages to writeback
    ////////////////////////////////////////

    for (genvar i = 0; i < pipe_pkg::alu_stages; i++) begin : g_stage
        pipe_pkg::wb_t d;
        pipe_pkg::wb_t q;

        if (i == 0) begin : g_head
            assign d = head;
        end else begin : g_tail
            assign d = g_stage[i-1].q;
        end

        // An invalid slot carries an all-zero payload
        always_ff @(posedge clock or negedge reset) begin
            if (!reset) begin
                q <= '0;
            end else if (!d.oper) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

    assign wb = g_stage[pipe_pkg::alu_stages-1].q;

endmodule

`default_nettype wire

//--- src/shifter.sv
`timescale 1ns/1ns
`default_nettype none

module shifter (
    input  logic [isa_pkg::data_width-1:0]  value,
    input  isa_pkg::shift_op_e              shift_op,
    input  logic [isa_pkg::shamt_width-1:0] shamt,
    output logic [isa_pkg::data_width-1:0]  result
);

    logic                           fill;
    logic [isa_pkg::data_width-1:0] stage;

    // Sign bit fills from the left only on arithmetic right shifts
    assign fill = (shift_op == isa_pkg::sh_sra) && value[isa_pkg::data_width-1];

    ////////////////////////////////////////
    // Log shifter with one level per amount bit
    ////////////////////////////////////////

    always_comb begin
        stage = value;
        for (int i = 0; i < isa_pkg::shamt_width; i++) begin
            if (shamt[i]) begin
                if (shift_op == isa_pkg::sh_sll) begin
                    stage = stage << (1 << i);
                end else if (fill) begin
                    // Shifting the complement brings in ones
                    stage = ~(~stage >> (1 << i));
                end else begin
                    stage = stage >> (1 << i);
                end
            end
        end
        result = stage;
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [isa_pkg::data_width-1:0] a,
    input  logic [isa_pkg::data_width-1:0] b,
    input  isa_pkg::alu_op_e               op,
    input  logic                           unsig,
    output logic [isa_pkg::data_width-1:0] result,
    output logic                           overflow
);

    logic [isa_pkg::data_width-1:0] sum;
    logic [isa_pkg::data_width-1:0] diff;
    logic                           add_ov;
    logic                           sub_ov;
    logic                           less;

    assign sum  = a + b;
    assign diff = a - b;

    // Operands of equal sign giving a sum of the other sign
    assign add_ov = (a[isa_pkg::data_width-1] == b[isa_pkg::data_width-1]) &&
                    (sum[isa_pkg::data_width-1] != a[isa_pkg::data_width-1]);

    // Operands of different sign and a difference with the sign of b
    assign sub_ov = (a[isa_pkg::data_width-1] != b[isa_pkg::data_width-1]) &&
                    (diff[isa_pkg::data_width-1] != a[isa_pkg::data_width-1]);

    assign less = unsig ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op)
            isa_pkg::alu_add: begin
                result   = sum;
                overflow = add_ov;
            end
            isa_pkg::alu_sub: begin
                result   = diff;
                overflow = sub_ov;
            end
            isa_pkg::alu_and:   result = a & b;
            isa_pkg::alu_or:    result = a | b;
            isa_pkg::alu_xor:   result = a ^ b;
            isa_pkg::alu_nor:   result = ~(a | b);
            isa_pkg::alu_slt:   result = {{(isa_pkg::data_width-1){1'b0}}, less};
            isa_pkg::alu_passb: result = b;
            default:            result = '0;
        endcase

        // Unsigned forms never trap
        if (unsig) begin
            overflow = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Register stages between issue and writeback
    localparam int alu_stages = 4;

    ////////////////////////////////////////
    // Issue bundle
    ////////////////////////////////////////

    typedef struct packed {
        logic                                    oper;
        // Take the shifter result instead of the ALU result
        logic                                    sel_shift;
        // Second ALU operand is imm_ext instead of regb
        logic                                    sel_imm;
        isa_pkg::alu_op_e                        alu_op;
        logic                                    unsig;
        isa_pkg::shift_op_e                      shift_op;
        logic [isa_pkg::shamt_width-1:0]         shamt;
        logic [isa_pkg::data_width-1:0]          rega;
        logic [isa_pkg::data_width-1:0]          regb;
        logic [isa_pkg::data_width-1:0]          imm_ext;
        logic [isa_pkg::reg_addr_width-1:0]      regdest;
        logic                                    writereg;
        // Write even when the ALU flags a signed overflow
        logic                                    writeov;
    } issue_t;

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////

    typedef struct packed {
        logic                               oper;
        logic [isa_pkg::reg_addr_width-1:0] regdest;
        logic                               writereg;
        logic [isa_pkg::data_width-1:0]     value;
    } wb_t;

endpackage

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    ////////////////////////////////////////
    // Word and field widths
    ////////////////////////////////////////

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int shamt_width    = 5;
    localparam int imm_width      = 16;
    localparam int reg_count      = 2 ** reg_addr_width;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Opcodes accepted by the issue stage
    typedef enum logic [4:0] {
        nop, add, addu, sub, subu,
        and_r, or_r, xor_r, nor_r, slt, sltu,
        addi, addiu, andi, ori, xori, lui,
        sll, srl, sra
    } opcode_e;

    // ALU operation in a 3 bit field
    typedef enum logic [2:0] {
        alu_add   = 3'd0,
        alu_sub   = 3'd1,
        alu_and   = 3'd2,
        alu_or    = 3'd3,
        alu_xor   = 3'd4,
        alu_nor   = 3'd5,
        alu_slt   = 3'd6,
        alu_passb = 3'd7
    } alu_op_e;

    // Shift operation with code 2'b11 left unused
    typedef enum logic [1:0] {
        sh_sll = 2'b00,
        sh_srl = 2'b01,
        sh_sra = 2'b10
    } shift_op_e;

    // Decoded instruction word as presented at the top level
    typedef struct packed {
        opcode_e                   opcode;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [reg_addr_width-1:0] rd;
        logic [shamt_width-1:0]    shamt;
        logic [imm_width-1:0]      imm;
    } instr_t;

endpackage

`default_nettype wire
